//--- verilog/ex_mem_pkg.sv
`default_nettype none

package ex_mem_pkg;

  localparam int unsigned xlen       = 32;
  localparam int unsigned reg_addr_w = 5;

  // alu opcodes as decoded for the execute stage.
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_lui
  } alu_op_e;

  typedef enum logic [1:0] {
    mem_none,
    mem_read,
    mem_write
  } mem_op_e;

  typedef enum logic [1:0] {
    src_alu,
    src_mem,
    src_link  // writes pc_plus4.
  } reg_src_e;

  typedef enum logic [1:0] {
    br_none,
    br_beq,
    br_bne
  } branch_e;

  // jmp_reg takes its target from the alu result, which is rs plus zero.
  typedef enum logic [1:0] {
    jmp_none,
    jmp_jump,
    jmp_reg
  } jump_e;

  typedef enum logic [1:0] {
    apb_idle,
    apb_setup,
    apb_access
  } apb_state_e;

endpackage

`default_nettype wire

//--- verilog/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
  input  ex_mem_pkg::alu_op_e                alu_op,
  input  logic                               alu_b_imm,
  input  logic [ex_mem_pkg::xlen-1:0]        rs_data,
  input  logic [ex_mem_pkg::xlen-1:0]        rt_data,
  input  logic [ex_mem_pkg::xlen-1:0]        imm,
  input  logic [ex_mem_pkg::xlen-1:0]        pc_plus4,
  output logic [ex_mem_pkg::xlen-1:0]        alu_result,
  output logic                               zero,
  output logic [ex_mem_pkg::xlen-1:0]        branch_target
);
  import ex_mem_pkg::*;

  logic [xlen-1:0] op_b;
  logic [xlen-1:0] rs_minus_rt;
  logic [4:0]      shamt;
  logic            lt_signed;
  logic            lt_unsigned;

  // imm arrives already sign extended from decode.
  assign op_b = alu_b_imm ? imm : rt_data;

  assign shamt       = op_b[4:0];
  assign lt_signed   = $signed(rs_data) < $signed(op_b);
  assign lt_unsigned = rs_data < op_b;

  // the branch compare always uses rt, whatever operand b was picked.
  assign rs_minus_rt = rs_data - rt_data;
  assign zero        = (rs_minus_rt == '0);

  always_comb begin
    case (alu_op)
      alu_add: begin
        alu_result = rs_data + op_b;
      end
      alu_sub: begin
        alu_result = rs_data - op_b;
      end
      alu_and: begin
        alu_result = rs_data & op_b;
      end
      alu_or: begin
        alu_result = rs_data | op_b;
      end
      alu_xor: begin
        alu_result = rs_data ^ op_b;
      end
      alu_slt: begin
        alu_result = {{(xlen-1){1'b0}}, lt_signed};
      end
      alu_sltu: begin
        alu_result = {{(xlen-1){1'b0}}, lt_unsigned};
      end
      alu_sll: begin
        alu_result = rs_data << shamt;
      end
      alu_srl: begin
        alu_result = rs_data >> shamt;
      end
      alu_lui: begin
        alu_result = {op_b[15:0], 16'h0000};  // upper half from the immediate.
      end
      default: begin
        alu_result = '0;
      end
    endcase
  end

  // word offset in imm, relative to the instruction after the branch.
  assign branch_target = pc_plus4 + {imm[xlen-3:0], 2'b00};

endmodule

`default_nettype wire

//--- verilog/ex_mem_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               stall,
  input  logic                               flush,
  input  logic                               in_valid,
  input  ex_mem_pkg::mem_op_e                in_mem_op,
  input  logic                               in_word_byte,
  input  ex_mem_pkg::reg_src_e               in_reg_src,
  input  logic                               in_reg_write,
  input  ex_mem_pkg::branch_e                in_branch,
  input  ex_mem_pkg::jump_e                  in_jump,
  input  logic [ex_mem_pkg::xlen-1:0]        in_alu_result,
  input  logic                               in_zero,
  input  logic [ex_mem_pkg::xlen-1:0]        in_branch_target,
  input  logic [ex_mem_pkg::xlen-1:0]        in_store_data,
  input  logic [ex_mem_pkg::xlen-1:0]        in_pc_plus4,
  input  logic [ex_mem_pkg::reg_addr_w-1:0]  in_dest,
  output logic                               out_valid,
  output ex_mem_pkg::mem_op_e                out_mem_op,
  output logic                               out_word_byte,
  output ex_mem_pkg::reg_src_e               out_reg_src,
  output logic                               out_reg_write,
  output ex_mem_pkg::branch_e                out_branch,
  output ex_mem_pkg::jump_e                  out_jump,
  output logic [ex_mem_pkg::xlen-1:0]        out_alu_result,
  output logic                               out_zero,
  output logic [ex_mem_pkg::xlen-1:0]        out_branch_target,
  output logic [ex_mem_pkg::xlen-1:0]        out_store_data,
  output logic [ex_mem_pkg::xlen-1:0]        out_pc_plus4,
  output logic [ex_mem_pkg::reg_addr_w-1:0]  out_dest
);
  import ex_mem_pkg::*;

  // a flush only affects the entry being written, so it waits for stall to drop.
  always_ff @(posedge clk) begin
    if (reset || (flush && !stall)) begin
      out_valid     <= 1'b0;
      out_mem_op    <= mem_none;
      out_word_byte <= 1'b0;
      out_reg_src   <= src_alu;
      out_reg_write <= 1'b0;
      out_branch    <= br_none;
      out_jump      <= jmp_none;
    end else if (!stall) begin
      out_valid     <= in_valid;
      out_mem_op    <= in_mem_op;
      out_word_byte <= in_word_byte;
      out_reg_src   <= in_reg_src;
      out_reg_write <= in_reg_write;
      out_branch    <= in_branch;
      out_jump      <= in_jump;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      out_alu_result    <= in_alu_result;
      out_zero          <= in_zero;
      out_branch_target <= in_branch_target;
      out_store_data    <= in_store_data;
      out_pc_plus4      <= in_pc_plus4;
      out_dest          <= in_dest;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mem_access_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_stage #(
  parameter int unsigned addr_width = 16
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               valid,
  input  ex_mem_pkg::mem_op_e                mem_op,
  input  logic                               word_byte,  // high for a byte access.
  input  ex_mem_pkg::reg_src_e               reg_src,
  input  logic                               reg_write,
  input  ex_mem_pkg::branch_e                branch,
  input  ex_mem_pkg::jump_e                  jump,
  input  logic [ex_mem_pkg::xlen-1:0]        alu_result,
  input  logic                               zero,
  input  logic [ex_mem_pkg::xlen-1:0]        branch_target,
  input  logic [ex_mem_pkg::xlen-1:0]        store_data,
  input  logic [ex_mem_pkg::xlen-1:0]        pc_plus4,
  input  logic [ex_mem_pkg::reg_addr_w-1:0]  dest,
  input  logic                               pready,
  input  logic [ex_mem_pkg::xlen-1:0]        prdata,
  output logic                               stall,
  output logic                               retire,
  output logic                               wb_valid,
  output logic [ex_mem_pkg::reg_addr_w-1:0]  wb_dest,
  output logic [ex_mem_pkg::xlen-1:0]        wb_data,
  output logic                               redirect,
  output logic [ex_mem_pkg::xlen-1:0]        redirect_addr,
  output logic [addr_width-1:0]              paddr,
  output logic                               psel,
  output logic                               penable,
  output logic                               pwrite,
  output logic [ex_mem_pkg::xlen-1:0]        pwdata,
  output logic [ex_mem_pkg::xlen/8-1:0]      pstrb
);
  import ex_mem_pkg::*;

  apb_state_e      state;
  apb_state_e      phase;
  logic            mem_pending;
  logic            xfer_done;
  logic            taken;
  logic [1:0]      lane;
  logic [7:0]      load_byte;
  logic [xlen-1:0] load_data;

  assign mem_pending = valid && (mem_op != mem_none);
  assign lane        = alu_result[1:0];

  // the register only records that access has begun. The setup cycle is the
  // first cycle a memory instruction sits in the register with state idle.
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= apb_idle;
    end else begin
      case (state)
        apb_idle: begin
          if (mem_pending) state <= apb_access;
        end
        apb_access: begin
          if (pready) state <= apb_idle;
        end
        default: begin
          state <= apb_idle;
        end
      endcase
    end
  end

  always_comb begin
    phase = state;
    if (state == apb_idle && mem_pending) phase = apb_setup;
  end

  assign xfer_done = (phase == apb_access) && pready;
  assign stall     = mem_pending && !xfer_done;
  assign retire    = valid && !stall;  // non-memory instructions leave at once.

  assign psel    = (phase == apb_setup) || (phase == apb_access);
  assign penable = (phase == apb_access);
  assign pwrite  = (mem_op == mem_write);
  assign paddr   = word_byte ? alu_result[addr_width-1:0]
                             : {alu_result[addr_width-1:2], 2'b00};

  // a byte store is replicated on every lane and the strobe picks the one written.
  assign pwdata = word_byte ? {4{store_data[7:0]}} : store_data;
  assign pstrb  = word_byte ? (4'b0001 << lane) : 4'b1111;

  always_comb begin
    case (lane)
      2'd0:    load_byte = prdata[7:0];
      2'd1:    load_byte = prdata[15:8];
      2'd2:    load_byte = prdata[23:16];
      default: load_byte = prdata[31:24];
    endcase
  end

  assign load_data = word_byte ? {{(xlen-8){1'b0}}, load_byte} : prdata;

  always_comb begin
    case (reg_src)
      src_mem:  wb_data = load_data;
      src_link: wb_data = pc_plus4;
      default:  wb_data = alu_result;
    endcase
  end

  assign wb_valid = retire && reg_write;
  assign wb_dest  = dest;

  always_comb begin
    case (branch)
      br_beq:  taken = zero;
      br_bne:  taken = !zero;
      default: taken = 1'b0;
    endcase
  end

  assign redirect      = retire && (taken || (jump != jmp_none));
  assign redirect_addr = (jump == jmp_reg) ? alu_result : branch_target;

endmodule

`default_nettype wire

//--- verilog/ex_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mem_top #(
  parameter int unsigned addr_width = 16
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               flush,
  input  logic                               id_valid,
  input  ex_mem_pkg::alu_op_e                id_alu_op,
  input  logic                               id_alu_b_imm,
  input  ex_mem_pkg::mem_op_e                id_mem_op,
  input  logic                               id_word_byte,
  input  ex_mem_pkg::reg_src_e               id_reg_src,
  input  logic                               id_reg_write,
  input  ex_mem_pkg::branch_e                id_branch,
  input  ex_mem_pkg::jump_e                  id_jump,
  input  logic [ex_mem_pkg::xlen-1:0]        id_rs_data,
  input  logic [ex_mem_pkg::xlen-1:0]        id_rt_data,
  input  logic [ex_mem_pkg::xlen-1:0]        id_imm,
  input  logic [ex_mem_pkg::xlen-1:0]        id_pc_plus4,
  input  logic [ex_mem_pkg::reg_addr_w-1:0]  id_dest,
  output logic                               stall,
  output logic                               retire,
  output logic                               wb_valid,
  output logic [ex_mem_pkg::reg_addr_w-1:0]  wb_dest,
  output logic [ex_mem_pkg::xlen-1:0]        wb_data,
  output logic                               redirect,
  output logic [ex_mem_pkg::xlen-1:0]        redirect_addr,
  output logic [addr_width-1:0]              paddr,
  output logic                               psel,
  output logic                               penable,
  output logic                               pwrite,
  output logic [ex_mem_pkg::xlen-1:0]        pwdata,
  output logic [ex_mem_pkg::xlen/8-1:0]      pstrb,
  input  logic                               pready,
  input  logic [ex_mem_pkg::xlen-1:0]        prdata
);
  import ex_mem_pkg::*;

  logic [xlen-1:0]       ex_alu_result;
  logic                  ex_zero;
  logic [xlen-1:0]       ex_branch_target;
  logic                  in_valid;
  logic                  m_valid;
  mem_op_e               m_mem_op;
  logic                  m_word_byte;
  reg_src_e              m_reg_src;
  logic                  m_reg_write;
  branch_e               m_branch;
  jump_e                 m_jump;
  logic [xlen-1:0]       m_alu_result;
  logic                  m_zero;
  logic [xlen-1:0]       m_branch_target;
  logic [xlen-1:0]       m_store_data;
  logic [xlen-1:0]       m_pc_plus4;
  logic [reg_addr_w-1:0] m_dest;

  assign in_valid = id_valid && !stall;

  exec_stage u_exec (
    .alu_op(id_alu_op), .alu_b_imm(id_alu_b_imm), .rs_data(id_rs_data),
    .rt_data(id_rt_data), .imm(id_imm), .pc_plus4(id_pc_plus4),
    .alu_result(ex_alu_result), .zero(ex_zero), .branch_target(ex_branch_target)
  );

  // the store data is rt, straight from decode.
  ex_mem_reg u_ex_mem_reg (
    .clk(clk), .reset(reset), .stall(stall), .flush(flush), .in_valid(in_valid),
    .in_mem_op(id_mem_op), .in_word_byte(id_word_byte), .in_reg_src(id_reg_src),
    .in_reg_write(id_reg_write), .in_branch(id_branch), .in_jump(id_jump),
    .in_alu_result(ex_alu_result), .in_zero(ex_zero), .in_branch_target(ex_branch_target),
    .in_store_data(id_rt_data), .in_pc_plus4(id_pc_plus4), .in_dest(id_dest),
    .out_valid(m_valid), .out_mem_op(m_mem_op), .out_word_byte(m_word_byte),
    .out_reg_src(m_reg_src), .out_reg_write(m_reg_write), .out_branch(m_branch),
    .out_jump(m_jump), .out_alu_result(m_alu_result), .out_zero(m_zero),
    .out_branch_target(m_branch_target), .out_store_data(m_store_data),
    .out_pc_plus4(m_pc_plus4), .out_dest(m_dest)
  );

  mem_access_stage #(.addr_width(addr_width)) u_mem (
    .clk(clk), .reset(reset), .valid(m_valid), .mem_op(m_mem_op),
    .word_byte(m_word_byte), .reg_src(m_reg_src), .reg_write(m_reg_write),
    .branch(m_branch), .jump(m_jump), .alu_result(m_alu_result), .zero(m_zero),
    .branch_target(m_branch_target), .store_data(m_store_data),
    .pc_plus4(m_pc_plus4), .dest(m_dest), .pready(pready), .prdata(prdata),
    .stall(stall), .retire(retire), .wb_valid(wb_valid), .wb_dest(wb_dest),
    .wb_data(wb_data), .redirect(redirect), .redirect_addr(redirect_addr),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pwdata(pwdata), .pstrb(pstrb)
  );

endmodule

`default_nettype wire

//--- verification/apb_ram_model.sv
`timescale 1ns/1ps
`default_nettype none

module apb_ram_model #(
  parameter int unsigned addr_width = 16
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [addr_width-1:0] paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [31:0]           pwdata,
  input  logic [3:0]            pstrb,
  output logic                  pready,
  output logic [31:0]           prdata
);

  localparam int unsigned depth = 2 ** (addr_width - 2);

  logic [31:0] mem [0:depth-1];
  logic [1:0]  wait_cnt;
  logic [addr_width-3:0] word_addr;

  // every word gets a value built from its full index.
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = {i[15:0], ~i[15:0]} ^ 32'h5a5a_0000;
    end
  end

  assign word_addr = paddr[addr_width-1:2];
  assign pready    = psel && penable && (wait_cnt == 2'd0);
  assign prdata    = mem[word_addr];

  always @(posedge clk) begin
    if (reset) begin
      wait_cnt <= 2'd0;
    end else if (psel && !penable) begin
      wait_cnt <= 2'($urandom_range(3, 0));  // wait states for this transfer.
    end else if (psel && penable) begin
      if (wait_cnt != 2'd0) begin
        wait_cnt <= wait_cnt - 2'd1;
      end else if (pwrite) begin
        for (int b = 0; b < 4; b++) begin
          if (pstrb[b]) mem[word_addr][8*b +: 8] <= pwdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_ex_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_mem;
  import ex_mem_pkg::*;

  typedef struct {
    alu_op_e     op;
    logic        bimm;
    mem_op_e     mop;
    logic        wb;
    reg_src_e    src;
    logic        rw;
    branch_e     br;
    jump_e       jp;
    logic [31:0] rs;
    logic [31:0] rt;
    logic [31:0] imm;
    logic [31:0] pc4;
    logic [4:0]  dest;
    logic        fl;
  } row_t;

  typedef struct {
    logic [4:0]  dest;
    logic        rw;
    logic [31:0] data;
    logic        redir;
    logic [31:0] raddr;
    logic        is_mem;
    logic        wr;
    logic [15:0] addr;
    logic [3:0]  strb;
    logic [31:0] wdata;
    int          cyc;
  } exp_t;

  logic clk;
  logic reset;
  logic flush;
  logic id_valid;
  alu_op_e id_alu_op;
  logic id_alu_b_imm;
  mem_op_e id_mem_op;
  logic id_word_byte;
  reg_src_e id_reg_src;
  logic id_reg_write;
  branch_e id_branch;
  jump_e id_jump;
  logic [31:0] id_rs_data;
  logic [31:0] id_rt_data;
  logic [31:0] id_imm;
  logic [31:0] id_pc_plus4;
  logic [4:0] id_dest;
  logic stall;
  logic retire;
  logic wb_valid;
  logic [4:0] wb_dest;
  logic [31:0] wb_data;
  logic redirect;
  logic [31:0] redirect_addr;
  logic [15:0] paddr;
  logic psel;
  logic penable;
  logic pwrite;
  logic [31:0] pwdata;
  logic [3:0] pstrb;
  logic pready;
  logic [31:0] prdata;

  row_t rows[$];
  exp_t exp_q[$];
  logic [31:0] shadow [int];
  int errors = 0;
  int checks = 0;
  int cycle = 0;
  logic started = 1'b0;
  logic rows_ready = 1'b0;
  logic in_access = 1'b0;  // the head's setup cycle has been seen.

  ex_mem_top #(.addr_width(16)) DUT (
    .clk(clk), .reset(reset), .flush(flush), .id_valid(id_valid),
    .id_alu_op(id_alu_op), .id_alu_b_imm(id_alu_b_imm), .id_mem_op(id_mem_op),
    .id_word_byte(id_word_byte), .id_reg_src(id_reg_src), .id_reg_write(id_reg_write),
    .id_branch(id_branch), .id_jump(id_jump), .id_rs_data(id_rs_data),
    .id_rt_data(id_rt_data), .id_imm(id_imm), .id_pc_plus4(id_pc_plus4),
    .id_dest(id_dest), .stall(stall), .retire(retire), .wb_valid(wb_valid),
    .wb_dest(wb_dest), .wb_data(wb_data), .redirect(redirect),
    .redirect_addr(redirect_addr), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .pstrb(pstrb), .pready(pready), .prdata(prdata)
  );

  apb_ram_model #(.addr_width(16)) u_ram (
    .clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .pstrb(pstrb), .pready(pready), .prdata(prdata)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] ref_alu(alu_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_and:  return a & b;
      alu_or:   return a | b;
      alu_xor:  return a ^ b;
      alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      alu_sll:  return a << b[4:0];
      alu_srl:  return a >> b[4:0];
      default:  return {b[15:0], 16'h0000};
    endcase
  endfunction

  // expected retire record for one row. Stores update the shadow copy in program order.
  function automatic exp_t predict(row_t r, int cyc);
    exp_t e;
    logic [31:0] alu;
    logic [31:0] w;
    int key;
    int lane;
    alu = ref_alu(r.op, r.rs, r.bimm ? r.imm : r.rt);
    key = int'(alu[15:2]);
    lane = int'(alu[1:0]);
    e.dest = r.dest;
    e.rw = r.rw;
    e.is_mem = (r.mop != mem_none);
    e.wr = (r.mop == mem_write);
    e.addr = r.wb ? alu[15:0] : {alu[15:2], 2'b00};
    e.strb = r.wb ? (4'b0001 << lane) : 4'b1111;
    e.wdata = r.wb ? {4{r.rt[7:0]}} : r.rt;
    e.cyc = cyc;
    w = shadow.exists(key) ? shadow[key] : 32'h0;
    if (e.wr) begin
      for (int b = 0; b < 4; b++) begin
        if (e.strb[b]) w[8*b +: 8] = e.wdata[8*b +: 8];
      end
      shadow[key] = w;
    end
    case (r.src)
      src_link: e.data = r.pc4;
      src_mem:  e.data = r.wb ? {24'h0, w[8*lane +: 8]} : w;
      default:  e.data = alu;
    endcase
    e.redir = (r.br == br_beq && r.rs == r.rt) || (r.br == br_bne && r.rs != r.rt) ||
              (r.jp != jmp_none);
    e.raddr = (r.jp == jmp_reg) ? alu : r.pc4 + (r.imm << 2);
    return e;
  endfunction

  task automatic alu_row(alu_op_e op, logic bimm, logic [31:0] rs, logic [31:0] rt,
                         logic [31:0] imm, logic [4:0] dest, logic fl);
    rows.push_back('{op, bimm, mem_none, 1'b0, src_alu, 1'b1, br_none, jmp_none,
                     rs, rt, imm, 32'h0, dest, fl});
  endtask

  task automatic mem_row(logic wr, logic wb, logic [31:0] addr, logic [31:0] data,
                         logic [4:0] dest);
    rows.push_back('{alu_add, 1'b1, wr ? mem_write : mem_read, wb, src_mem, !wr,
                     br_none, jmp_none, addr, data, 32'h0, 32'h0, dest, 1'b0});
  endtask

  task automatic ctl_row(branch_e br, jump_e jp, logic [31:0] rs, logic [31:0] rt,
                         logic [31:0] imm, logic [31:0] pc4, logic [4:0] dest);
    rows.push_back('{alu_add, jp == jmp_reg, mem_none, 1'b0, src_link, jp != jmp_none,
                     br, jp, rs, rt, imm, pc4, dest, 1'b0});
  endtask

  task automatic build_table();
    alu_row(alu_add, 1'b0, 32'h0000_1234, 32'h0000_0011, 32'h0, 5'd1, 1'b0);
    alu_row(alu_add, 1'b1, 32'h1000_0000, 32'h0, 32'hffff_fff0, 5'd2, 1'b0);
    alu_row(alu_sub, 1'b0, 32'h10, 32'h30, 32'h0, 5'd3, 1'b0);
    alu_row(alu_and, 1'b0, 32'hf0f0_ff00, 32'h0ff0_f0f0, 32'h0, 5'd4, 1'b0);
    alu_row(alu_or, 1'b1, 32'h1200_0000, 32'h0, 32'h0000_5678, 5'd5, 1'b0);
    alu_row(alu_xor, 1'b0, 32'haaaa_5555, 32'hffff_0000, 32'h0, 5'd6, 1'b0);
    alu_row(alu_slt, 1'b0, 32'hffff_fff0, 32'h5, 32'h0, 5'd7, 1'b0);
    alu_row(alu_sltu, 1'b0, 32'hffff_fff0, 32'h5, 32'h0, 5'd8, 1'b0);
    alu_row(alu_sll, 1'b1, 32'h8000_0003, 32'h0, 32'h4, 5'd9, 1'b0);
    alu_row(alu_srl, 1'b0, 32'h8000_0000, 32'h1f, 32'h0, 5'd10, 1'b0);
    alu_row(alu_lui, 1'b1, 32'h0, 32'h0, 32'h0000_beef, 5'd11, 1'b0);
    alu_row(alu_add, 1'b0, 32'h1, 32'h2, 32'h0, 5'd12, 1'b1);  // flushed, never retires.
    mem_row(1'b1, 1'b0, 32'h100, 32'hcafe_f00d, 5'd0);
    mem_row(1'b0, 1'b0, 32'h102, 32'h0, 5'd13);
    mem_row(1'b1, 1'b1, 32'h200, 32'h11, 5'd0);
    mem_row(1'b1, 1'b1, 32'h201, 32'h22, 5'd0);
    mem_row(1'b1, 1'b1, 32'h202, 32'h33, 5'd0);
    mem_row(1'b1, 1'b1, 32'h203, 32'h44, 5'd0);
    mem_row(1'b0, 1'b0, 32'h200, 32'h0, 5'd14);
    mem_row(1'b0, 1'b1, 32'h201, 32'h0, 5'd15);
    mem_row(1'b0, 1'b1, 32'h203, 32'h0, 5'd16);
    ctl_row(br_beq, jmp_none, 32'h5, 32'h5, 32'h10, 32'h400, 5'd0);
    ctl_row(br_beq, jmp_none, 32'h5, 32'h6, 32'h10, 32'h404, 5'd0);
    ctl_row(br_bne, jmp_none, 32'h5, 32'h6, 32'hffff_fffc, 32'h408, 5'd0);
    ctl_row(br_bne, jmp_none, 32'h5, 32'h5, 32'h8, 32'h40c, 5'd0);
    ctl_row(br_none, jmp_jump, 32'h0, 32'h0, 32'h40, 32'h500, 5'd31);
    ctl_row(br_none, jmp_reg, 32'h0000_0800, 32'h0, 32'h0, 32'h600, 5'd31);
    alu_row(alu_add, 1'b0, 32'h7, 32'h8, 32'h0, 5'd17, 1'b0);
  endtask

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic drive_row(row_t r);
    id_valid <= 1'b1;
    id_alu_op <= r.op;
    id_alu_b_imm <= r.bimm;
    id_mem_op <= r.mop;
    id_word_byte <= r.wb;
    id_reg_src <= r.src;
    id_reg_write <= r.rw;
    id_branch <= r.br;
    id_jump <= r.jp;
    id_rs_data <= r.rs;
    id_rt_data <= r.rt;
    id_imm <= r.imm;
    id_pc_plus4 <= r.pc4;
    id_dest <= r.dest;
    flush <= r.fl;
  endtask

  // outputs are sampled on the falling edge, halfway between driver updates.
  always @(negedge clk) begin
    exp_t head;
    logic exp_stall;
    if (!reset && started) begin
      exp_stall = 1'b0;
      if (exp_q.size() != 0) begin
        head = exp_q[0];
        exp_stall = head.is_mem && !(in_access && pready);
        check("psel", psel, head.is_mem);
        check("penable", penable, head.is_mem && in_access);
        check("stall", stall, exp_stall);
        if (psel) begin
          check("paddr", paddr, head.addr);
          check("pwrite", pwrite, head.wr);
          check("pstrb", pstrb, head.strb);
          if (head.wr) check("pwdata", pwdata, head.wdata);
        end
      end else begin
        check("stall", stall, 1'b0);
        check("psel", psel, 1'b0);
        check("penable", penable, 1'b0);
      end
      check("retire", retire, (exp_q.size() != 0) && !exp_stall);
      if (retire) begin
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("retire at %0t ns with no instruction outstanding", $time);
        end
        if (exp_q.size() != 0) begin
          head = exp_q.pop_front();
          check("wb_valid", wb_valid, head.rw);
          check("redirect", redirect, head.redir);
          if (head.rw) check("wb_dest", wb_dest, head.dest);
          if (head.rw) check("wb_data", wb_data, head.data);
          if (head.redir) check("redirect_addr", redirect_addr, head.raddr);
          if (!head.is_mem) check("latency", cycle - head.cyc, 1);
          assert (!head.is_mem || cycle - head.cyc >= 2) else begin
            errors++;
            $display("memory instruction retired too early at %0t ns", $time);
          end
        end
        in_access = 1'b0;
      end else begin
        check("wb_valid", wb_valid, 1'b0);
        check("redirect", redirect, 1'b0);
        if (exp_q.size() != 0 && exp_q[0].is_mem) in_access = 1'b1;
      end
    end
  end

  initial begin
    wait (rows_ready);
    repeat (rows.size() * 10 + 16) @(posedge clk);
    $display("watchdog expired at %0t ns with %0d retires outstanding", $time, exp_q.size());
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int cyc;
    void'($urandom(32'h03b2_6b41));
    reset = 1'b1;
    flush = 1'b0;
    id_valid = 1'b0;
    id_alu_op = alu_add;
    id_alu_b_imm = 1'b0;
    id_mem_op = mem_none;
    id_word_byte = 1'b0;
    id_reg_src = src_alu;
    id_reg_write = 1'b0;
    id_branch = br_none;
    id_jump = jmp_none;
    id_rs_data = '0;
    id_rt_data = '0;
    id_imm = '0;
    id_pc_plus4 = '0;
    id_dest = '0;
    build_table();
    rows_ready = 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    started <= 1'b1;
    @(posedge clk);  // one idle cycle so the monitor sees the state after reset.
    foreach (rows[i]) begin
      drive_row(rows[i]);
      do @(negedge clk); while (stall);
      cyc = cycle;
      @(posedge clk);
      if (!rows[i].fl) begin
        exp_q.push_back(predict(rows[i], cyc));
      end
    end
    id_valid <= 1'b0;
    flush <= 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (3) @(posedge clk);
    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
verilog/ex_mem_pkg.sv
verilog/exec_stage.sv
verilog/ex_mem_reg.sv
verilog/mem_access_stage.sv
verilog/ex_mem_top.sv
verification/apb_ram_model.sv
verification/tb_ex_mem.sv

//--- Bender.yml
package:
  name: ex_mem

sources:
  - files:
      - verilog/ex_mem_pkg.sv
      - verilog/exec_stage.sv
      - verilog/ex_mem_reg.sv
      - verilog/mem_access_stage.sv
      - verilog/ex_mem_top.sv
  - target: test
    files:
      - verification/apb_ram_model.sv
      - verification/tb_ex_mem.sv
